/* source/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_OP_IMM = 7'b0010011,
    OP_OP     = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } op_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } itype_t;

  // One instruction word seen through both field layouts.
  typedef union packed {
    rtype_t r;
    itype_t i;
  } insn_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_control_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_op_e;

  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
  } mem_op_e;

  typedef enum logic [2:0] {CF_NONE, CF_JAL, CF_JALR, CF_BRANCH} cf_op_e;

  typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_e;  // Matches funct3[1:0].

  localparam logic [30:0] MCAUSE_ILLEGAL = 31'd2;
  localparam logic [30:0] MCAUSE_BREAK   = 31'd3;
  localparam logic [30:0] MCAUSE_ECALL   = 31'd11;

  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE   = 12'hB00;

endpackage

/* source/decoder.sv */
`timescale 1ns/1ps

module decoder (
  input  rv_pkg::insn_u        insn_i,
  output logic                 rd_valid_o,
  output logic                 rs1_valid_o,
  output logic                 rs2_valid_o,
  output rv_pkg::alu_control_e alu_control_o,
  output rv_pkg::imm_op_e      imm_op_o,
  output rv_pkg::mem_op_e      mem_op_o,
  output rv_pkg::cf_op_e       cf_op_o,
  output rv_pkg::csr_op_e      csr_op_o,
  output logic                 csr_imm_o,
  output logic                 trap_valid_o,
  output logic [30:0]          trap_mcause_o
);

  rv_pkg::op_e op;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        alt;
  logic        is_op;
  logic        funct7_bad;
  logic        alt_ok;
  logic        csr_known;
  logic        mcycle_write;
  logic        illegal;

  assign op     = rv_pkg::op_e'(insn_i.i.opcode);
  assign funct3 = insn_i.i.funct3;
  assign funct7 = insn_i.r.funct7;
  assign alt    = funct7[5];  // Alternate ALU select.
  assign is_op  = (op == rv_pkg::OP_OP);

  // Only funct7 bit 5 may be set, and only for SUB, SRA and SRAI.
  assign funct7_bad = |(funct7 & 7'b1011111);
  assign alt_ok     = (funct3 == 3'b101) || (is_op && funct3 == 3'b000);

  assign csr_known = insn_i.i.imm12 inside {rv_pkg::CSR_MSCRATCH, rv_pkg::CSR_MTVEC,
                                            rv_pkg::CSR_MEPC, rv_pkg::CSR_MCAUSE,
                                            rv_pkg::CSR_MCYCLE};
  assign mcycle_write = (insn_i.i.imm12 == rv_pkg::CSR_MCYCLE) &&
                        (funct3[1:0] == 2'b01 || insn_i.i.rs1 != '0);

  always_comb begin
    rd_valid_o    = 1'b0;
    rs1_valid_o   = 1'b0;
    rs2_valid_o   = 1'b0;
    alu_control_o = rv_pkg::ALU_ADD;
    imm_op_o      = rv_pkg::IMM_I;
    mem_op_o      = rv_pkg::MEM_NONE;
    cf_op_o       = rv_pkg::CF_NONE;
    csr_op_o      = rv_pkg::CSR_NONE;
    csr_imm_o     = 1'b0;
    trap_valid_o  = 1'b0;
    trap_mcause_o = '0;
    illegal       = 1'b0;
    case (op)
      rv_pkg::OP_LUI: begin
        rd_valid_o    = 1'b1;
        imm_op_o      = rv_pkg::IMM_U;
        alu_control_o = rv_pkg::ALU_PASS_B;
      end
      rv_pkg::OP_AUIPC: begin
        rd_valid_o = 1'b1;
        imm_op_o   = rv_pkg::IMM_U;
      end
      rv_pkg::OP_JAL: begin
        rd_valid_o = 1'b1;
        imm_op_o   = rv_pkg::IMM_J;
        cf_op_o    = rv_pkg::CF_JAL;
      end
      rv_pkg::OP_JALR: begin
        rd_valid_o  = 1'b1;
        rs1_valid_o = 1'b1;
        cf_op_o     = rv_pkg::CF_JALR;
        illegal     = (funct3 != 3'b000);
      end
      rv_pkg::OP_BRANCH: begin
        rs1_valid_o = 1'b1;
        rs2_valid_o = 1'b1;
        imm_op_o    = rv_pkg::IMM_B;
        cf_op_o     = rv_pkg::CF_BRANCH;
        case (funct3[2:1])
          2'b00:   alu_control_o = rv_pkg::ALU_SUB;  // beq, bne.
          2'b10:   alu_control_o = rv_pkg::ALU_SLT;
          2'b11:   alu_control_o = rv_pkg::ALU_SLTU;
          default: illegal = 1'b1;
        endcase
      end
      rv_pkg::OP_LOAD: begin
        rd_valid_o  = 1'b1;
        rs1_valid_o = 1'b1;
        case (funct3)
          3'b000:  mem_op_o = rv_pkg::MEM_LB;
          3'b001:  mem_op_o = rv_pkg::MEM_LH;
          3'b010:  mem_op_o = rv_pkg::MEM_LW;
          3'b100:  mem_op_o = rv_pkg::MEM_LBU;
          3'b101:  mem_op_o = rv_pkg::MEM_LHU;
          default: illegal = 1'b1;
        endcase
      end
      rv_pkg::OP_STORE: begin
        rs1_valid_o = 1'b1;
        rs2_valid_o = 1'b1;
        imm_op_o    = rv_pkg::IMM_S;
        case (funct3)
          3'b000:  mem_op_o = rv_pkg::MEM_SB;
          3'b001:  mem_op_o = rv_pkg::MEM_SH;
          3'b010:  mem_op_o = rv_pkg::MEM_SW;
          default: illegal = 1'b1;
        endcase
      end
      rv_pkg::OP_OP_IMM, rv_pkg::OP_OP: begin
        rd_valid_o  = 1'b1;
        rs1_valid_o = 1'b1;
        rs2_valid_o = is_op;
        case (funct3)
          3'b000:  alu_control_o = (is_op && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001:  alu_control_o = rv_pkg::ALU_SLL;
          3'b010:  alu_control_o = rv_pkg::ALU_SLT;
          3'b011:  alu_control_o = rv_pkg::ALU_SLTU;
          3'b100:  alu_control_o = rv_pkg::ALU_XOR;
          3'b101:  alu_control_o = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          3'b110:  alu_control_o = rv_pkg::ALU_OR;
          default: alu_control_o = rv_pkg::ALU_AND;
        endcase
        if (is_op || funct3 == 3'b001 || funct3 == 3'b101)  // Immediate shifts too.
          illegal = funct7_bad || (alt && !alt_ok);
      end
      rv_pkg::OP_SYSTEM: begin
        if (funct3 == 3'b000) begin
          if (insn_i.i.rd != '0 || insn_i.i.rs1 != '0 || insn_i.i.imm12[11:1] != '0) begin
            illegal = 1'b1;
          end else begin
            trap_valid_o  = 1'b1;
            trap_mcause_o = insn_i.i.imm12[0] ? rv_pkg::MCAUSE_BREAK : rv_pkg::MCAUSE_ECALL;
          end
        end else if (funct3 == 3'b100 || !csr_known || mcycle_write) begin
          illegal = 1'b1;
        end else begin
          rd_valid_o  = 1'b1;
          rs1_valid_o = !funct3[2];
          csr_imm_o   = funct3[2];  // Zimm sits in the rs1 field.
          csr_op_o    = rv_pkg::csr_op_e'(funct3[1:0]);
        end
      end
      default: illegal = 1'b1;
    endcase

    if (illegal) begin
      rd_valid_o    = 1'b0;
      rs1_valid_o   = 1'b0;
      rs2_valid_o   = 1'b0;
      alu_control_o = rv_pkg::ALU_ADD;
      imm_op_o      = rv_pkg::IMM_I;
      mem_op_o      = rv_pkg::MEM_NONE;
      cf_op_o       = rv_pkg::CF_NONE;
      csr_op_o      = rv_pkg::CSR_NONE;
      csr_imm_o     = 1'b0;
      trap_valid_o  = 1'b1;
      trap_mcause_o = rv_pkg::MCAUSE_ILLEGAL;
    end
  end

endmodule

/* source/extend.sv */
`timescale 1ns/1ps

module extend (
  input  rv_pkg::insn_u           insn_i,
  input  rv_pkg::imm_op_e         imm_op_i,
  output logic [rv_pkg::XLEN-1:0] imm_o
);

  logic sign;

  assign sign = insn_i.r.funct7[6];  // Instruction bit 31.

  always_comb begin
    case (imm_op_i)
      rv_pkg::IMM_I: imm_o = {{20{sign}}, insn_i.i.imm12};
      rv_pkg::IMM_S: imm_o = {{20{sign}}, insn_i.r.funct7, insn_i.r.rd};
      rv_pkg::IMM_B: imm_o = {{20{sign}}, insn_i.r.rd[0], insn_i.r.funct7[5:0],
                              insn_i.r.rd[4:1], 1'b0};
      rv_pkg::IMM_U: imm_o = {insn_i.i.imm12, insn_i.i.rs1, insn_i.i.funct3, 12'b0};
      rv_pkg::IMM_J: imm_o = {{12{sign}}, insn_i.i.rs1, insn_i.i.funct3, insn_i.i.imm12[0],
                              insn_i.i.imm12[10:1], 1'b0};
      default:       imm_o = '0;
    endcase
  end

endmodule

/* source/regfile.sv */
`timescale 1ns/1ps

module regfile (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic [rv_pkg::XLEN-1:0]       rs1_rdata_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_rdata_o,
  input  logic                          we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [rv_pkg::XLEN-1:0]       rd_wdata_i
);

  logic [rv_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (we_i && rd_addr_i != '0) begin  // x0 is never written.
      regs[rd_addr_i] <= rd_wdata_i;
    end
  end

  assign rs1_rdata_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_rdata_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* source/csrfile.sv */
`timescale 1ns/1ps

module csrfile (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic [rv_pkg::CSR_ADDR_W-1:0] addr_i,
  output logic [rv_pkg::XLEN-1:0]       rdata_o,
  input  logic                          we_i,
  input  logic [rv_pkg::CSR_ADDR_W-1:0] waddr_i,
  input  logic [rv_pkg::XLEN-1:0]       wdata_i
);

  logic [rv_pkg::XLEN-1:0] mscratch;
  logic [rv_pkg::XLEN-1:0] mtvec;
  logic [rv_pkg::XLEN-1:0] mepc;
  logic [rv_pkg::XLEN-1:0] mcause;
  logic [rv_pkg::XLEN-1:0] mcycle;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mscratch <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mcycle   <= '0;
    end else begin
      mcycle <= mcycle + 1'b1;  // Free running.
      if (we_i) begin
        case (waddr_i)
          rv_pkg::CSR_MSCRATCH: mscratch <= wdata_i;
          rv_pkg::CSR_MTVEC:    mtvec    <= wdata_i;
          rv_pkg::CSR_MEPC:     mepc     <= wdata_i;
          rv_pkg::CSR_MCAUSE:   mcause   <= wdata_i;
          default: ;  // mcycle and unknown addresses drop the write.
        endcase
      end
    end
  end

  always_comb begin
    case (addr_i)
      rv_pkg::CSR_MSCRATCH: rdata_o = mscratch;
      rv_pkg::CSR_MTVEC:    rdata_o = mtvec;
      rv_pkg::CSR_MEPC:     rdata_o = mepc;
      rv_pkg::CSR_MCAUSE:   rdata_o = mcause;
      rv_pkg::CSR_MCYCLE:   rdata_o = mcycle;
      default:              rdata_o = '0;
    endcase
  end

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
  input  rv_pkg::insn_u                 insn_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  input  logic                          forward_a_i,
  input  logic                          forward_b_i,
  input  logic [rv_pkg::XLEN-1:0]       rs1_rdata_i,
  input  logic [rv_pkg::XLEN-1:0]       rs2_rdata_i,
  input  logic [rv_pkg::XLEN-1:0]       wb_rd_wdata_i,
  input  logic [rv_pkg::XLEN-1:0]       csr_rdata_i,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  output logic [rv_pkg::CSR_ADDR_W-1:0] csr_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_o,
  output logic [rv_pkg::XLEN-1:0]       op1_o,
  output logic [rv_pkg::XLEN-1:0]       op2_o,
  output logic [rv_pkg::XLEN-1:0]       imm_o,
  output rv_pkg::alu_control_e          alu_control_o,
  output rv_pkg::mem_op_e               mem_op_o,
  output rv_pkg::cf_op_e                cf_op_o,
  output rv_pkg::csr_op_e               csr_op_o,
  output logic [rv_pkg::XLEN-1:0]       csr_rdata_o,
  output logic                          trap_valid_o,
  output logic [30:0]                   trap_mcause_o
);

  logic                    rd_valid;
  logic                    rs1_valid;
  logic                    rs2_valid;
  logic                    csr_imm;
  logic                    pc_sel;
  rv_pkg::imm_op_e         imm_op;
  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;

  decoder decoder_i (
    .insn_i        (insn_i),
    .rd_valid_o    (rd_valid),
    .rs1_valid_o   (rs1_valid),
    .rs2_valid_o   (rs2_valid),
    .alu_control_o (alu_control_o),
    .imm_op_o      (imm_op),
    .mem_op_o      (mem_op_o),
    .cf_op_o       (cf_op_o),
    .csr_op_o      (csr_op_o),
    .csr_imm_o     (csr_imm),
    .trap_valid_o  (trap_valid_o),
    .trap_mcause_o (trap_mcause_o)
  );

  extend extend_i (
    .insn_i   (insn_i),
    .imm_op_i (imm_op),
    .imm_o    (imm_o)
  );

  // Unused fields read as x0 so they never match a write-back.
  assign rs1_addr_o  = rs1_valid ? insn_i.i.rs1 : '0;
  assign rs2_addr_o  = rs2_valid ? insn_i.r.rs2 : '0;
  assign rd_addr_o   = rd_valid ? insn_i.i.rd : '0;
  assign csr_addr_o  = (csr_op_o != rv_pkg::CSR_NONE) ? insn_i.i.imm12 : '0;
  assign csr_rdata_o = csr_rdata_i;

  assign rs1_data = forward_a_i ? wb_rd_wdata_i : rs1_rdata_i;
  assign rs2_data = forward_b_i ? wb_rd_wdata_i : rs2_rdata_i;

  // AUIPC and JAL add to the PC.
  assign pc_sel = (insn_i.i.opcode == rv_pkg::OP_AUIPC) || (cf_op_o == rv_pkg::CF_JAL);

  // A trap carries the faulting PC and instruction word in the operands.
  assign op1_o = (trap_valid_o || pc_sel) ? pc_i :
                 csr_imm ? {{(rv_pkg::XLEN-rv_pkg::REG_ADDR_W){1'b0}}, insn_i.i.rs1} :
                 rs1_data;
  assign op2_o = trap_valid_o ? insn_i : rs2_data;

endmodule

/* source/issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          insn_valid_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  input  logic                          wb_valid_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_addr_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  output logic                          forward_a_o,
  output logic                          forward_b_o,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [rv_pkg::XLEN-1:0]       op1_i,
  input  logic [rv_pkg::XLEN-1:0]       op2_i,
  input  logic [rv_pkg::XLEN-1:0]       imm_i,
  input  rv_pkg::alu_control_e          alu_control_i,
  input  rv_pkg::mem_op_e               mem_op_i,
  input  rv_pkg::cf_op_e                cf_op_i,
  input  rv_pkg::csr_op_e               csr_op_i,
  input  logic [rv_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic                          trap_valid_i,
  input  logic [30:0]                   trap_mcause_i,
  output logic                          ex_valid_o,
  output logic [rv_pkg::XLEN-1:0]       ex_pc_o,
  output logic [rv_pkg::XLEN-1:0]       ex_rs1_rdata_o,
  output logic [rv_pkg::XLEN-1:0]       ex_rs2_rdata_o,
  output logic [rv_pkg::XLEN-1:0]       ex_imm_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_addr_o,
  output rv_pkg::alu_control_e          ex_alu_control_o,
  output rv_pkg::mem_op_e               ex_mem_op_o,
  output rv_pkg::cf_op_e                ex_cf_op_o,
  output rv_pkg::csr_op_e               ex_csr_op_o,
  output logic [rv_pkg::XLEN-1:0]       ex_csr_rdata_o,
  output logic                          ex_trap_valid_o,
  output logic [30:0]                   ex_trap_mcause_o
);

  // Source addresses arrive gated, so x0 and unused fields never forward.
  assign forward_a_o = wb_valid_i && (wb_rd_addr_i != '0) && (wb_rd_addr_i == rs1_addr_i);
  assign forward_b_o = wb_valid_i && (wb_rd_addr_i != '0) && (wb_rd_addr_i == rs2_addr_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid_o       <= 1'b0;
      ex_rd_addr_o     <= '0;
      ex_alu_control_o <= rv_pkg::ALU_ADD;
      ex_mem_op_o      <= rv_pkg::MEM_NONE;
      ex_cf_op_o       <= rv_pkg::CF_NONE;
      ex_csr_op_o      <= rv_pkg::CSR_NONE;
      ex_trap_valid_o  <= 1'b0;
    end else begin
      ex_valid_o       <= insn_valid_i;
      ex_rd_addr_o     <= insn_valid_i ? rd_addr_i : '0;
      ex_alu_control_o <= insn_valid_i ? alu_control_i : rv_pkg::ALU_ADD;
      ex_mem_op_o      <= insn_valid_i ? mem_op_i : rv_pkg::MEM_NONE;
      ex_cf_op_o       <= insn_valid_i ? cf_op_i : rv_pkg::CF_NONE;
      ex_csr_op_o      <= insn_valid_i ? csr_op_i : rv_pkg::CSR_NONE;
      ex_trap_valid_o  <= insn_valid_i && trap_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_pc_o          <= pc_i;
    ex_rs1_rdata_o   <= op1_i;
    ex_rs2_rdata_o   <= op2_i;
    ex_imm_o         <= imm_i;
    ex_csr_rdata_o   <= csr_rdata_i;
    ex_trap_mcause_o <= trap_mcause_i;
  end

endmodule

/* source/decode_top.sv */
`timescale 1ns/1ps

module decode_top (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  logic                          insn_valid_i,
  input  logic [rv_pkg::XLEN-1:0]       insn_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  input  logic                          wb_valid_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_addr_i,
  input  logic [rv_pkg::XLEN-1:0]       wb_rd_wdata_i,
  input  logic                          wb_csr_we_i,
  input  logic [rv_pkg::CSR_ADDR_W-1:0] wb_csr_addr_i,
  input  logic [rv_pkg::XLEN-1:0]       wb_csr_wdata_i,
  output logic                          ex_valid_o,
  output logic [rv_pkg::XLEN-1:0]       ex_pc_o,
  output logic [rv_pkg::XLEN-1:0]       ex_rs1_rdata_o,
  output logic [rv_pkg::XLEN-1:0]       ex_rs2_rdata_o,
  output logic [rv_pkg::XLEN-1:0]       ex_imm_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_addr_o,
  output rv_pkg::alu_control_e          ex_alu_control_o,
  output rv_pkg::mem_op_e               ex_mem_op_o,
  output rv_pkg::cf_op_e                ex_cf_op_o,
  output rv_pkg::csr_op_e               ex_csr_op_o,
  output logic [rv_pkg::XLEN-1:0]       ex_csr_rdata_o,
  output logic                          ex_trap_valid_o,
  output logic [30:0]                   ex_trap_mcause_o
);

  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [rv_pkg::XLEN-1:0]       rs1_rdata, rs2_rdata;
  logic [rv_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic [rv_pkg::XLEN-1:0]       csr_rdata, id_csr_rdata;
  logic                          forward_a, forward_b;
  logic [rv_pkg::XLEN-1:0]       op1, op2, imm;
  rv_pkg::alu_control_e          alu_control;
  rv_pkg::mem_op_e               mem_op;
  rv_pkg::cf_op_e                cf_op;
  rv_pkg::csr_op_e               csr_op;
  logic                          trap_valid;
  logic [30:0]                   trap_mcause;

  regfile regfile_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rs1_addr_i  (rs1_addr),
    .rs2_addr_i  (rs2_addr),
    .rs1_rdata_o (rs1_rdata),
    .rs2_rdata_o (rs2_rdata),
    .we_i        (wb_valid_i),
    .rd_addr_i   (wb_rd_addr_i),
    .rd_wdata_i  (wb_rd_wdata_i)
  );

  csrfile csrfile_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .addr_i  (csr_addr),
    .rdata_o (csr_rdata),
    .we_i    (wb_csr_we_i),
    .waddr_i (wb_csr_addr_i),
    .wdata_i (wb_csr_wdata_i)
  );

  id_stage id_stage_i (
    .insn_i        (insn_i),
    .pc_i          (pc_i),
    .forward_a_i   (forward_a),
    .forward_b_i   (forward_b),
    .rs1_rdata_i   (rs1_rdata),
    .rs2_rdata_i   (rs2_rdata),
    .wb_rd_wdata_i (wb_rd_wdata_i),
    .csr_rdata_i   (csr_rdata),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .csr_addr_o    (csr_addr),
    .rd_addr_o     (rd_addr),
    .op1_o         (op1),
    .op2_o         (op2),
    .imm_o         (imm),
    .alu_control_o (alu_control),
    .mem_op_o      (mem_op),
    .cf_op_o       (cf_op),
    .csr_op_o      (csr_op),
    .csr_rdata_o   (id_csr_rdata),
    .trap_valid_o  (trap_valid),
    .trap_mcause_o (trap_mcause)
  );

  issue_ctrl issue_ctrl_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .insn_valid_i     (insn_valid_i),
    .pc_i             (pc_i),
    .wb_valid_i       (wb_valid_i),
    .wb_rd_addr_i     (wb_rd_addr_i),
    .rs1_addr_i       (rs1_addr),
    .rs2_addr_i       (rs2_addr),
    .forward_a_o      (forward_a),
    .forward_b_o      (forward_b),
    .rd_addr_i        (rd_addr),
    .op1_i            (op1),
    .op2_i            (op2),
    .imm_i            (imm),
    .alu_control_i    (alu_control),
    .mem_op_i         (mem_op),
    .cf_op_i          (cf_op),
    .csr_op_i         (csr_op),
    .csr_rdata_i      (id_csr_rdata),
    .trap_valid_i     (trap_valid),
    .trap_mcause_i    (trap_mcause),
    .ex_valid_o       (ex_valid_o),
    .ex_pc_o          (ex_pc_o),
    .ex_rs1_rdata_o   (ex_rs1_rdata_o),
    .ex_rs2_rdata_o   (ex_rs2_rdata_o),
    .ex_imm_o         (ex_imm_o),
    .ex_rd_addr_o     (ex_rd_addr_o),
    .ex_alu_control_o (ex_alu_control_o),
    .ex_mem_op_o      (ex_mem_op_o),
    .ex_cf_op_o       (ex_cf_op_o),
    .ex_csr_op_o      (ex_csr_op_o),
    .ex_csr_rdata_o   (ex_csr_rdata_o),
    .ex_trap_valid_o  (ex_trap_valid_o),
    .ex_trap_mcause_o (ex_trap_mcause_o)
  );

endmodule

/* tests/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker (
  input  logic        clk_i,
  input  logic        exp_active_i,
  input  int          exp_line_i,
  input  logic [31:0] exp_pc_i,
  input  logic [31:0] exp_cols_i [13],
  input  logic        ex_valid_i,
  input  logic [31:0] ex_pc_i,
  input  logic [31:0] ex_rs1_rdata_i,
  input  logic [31:0] ex_rs2_rdata_i,
  input  logic [31:0] ex_imm_i,
  input  logic [4:0]  ex_rd_addr_i,
  input  logic [3:0]  ex_alu_control_i,
  input  logic [3:0]  ex_mem_op_i,
  input  logic [2:0]  ex_cf_op_i,
  input  logic [1:0]  ex_csr_op_i,
  input  logic [31:0] ex_csr_rdata_i,
  input  logic        ex_trap_valid_i,
  input  logic [30:0] ex_trap_mcause_i
);

  int          check_count = 0;
  int          error_count = 0;
  logic        held_active = 1'b0;
  int          held_line;
  logic [31:0] held_pc;
  logic [31:0] held [13];

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("MISMATCH %s line %0d: expected 0x%08h, actual 0x%08h", name, held_line, exp, act);
    end
  endtask

  // Expected values are taken at the edge that samples the line.
  always @(posedge clk_i) begin
    held_active <= exp_active_i;
    held_line   <= exp_line_i;
    held_pc     <= exp_pc_i;
    held        <= exp_cols_i;
  end

  always @(negedge clk_i) begin
    if (held_active) begin
      check_field("ex_valid_o", held[1], {31'b0, ex_valid_i});
      check_field("ex_rd_addr_o", held[5], {27'b0, ex_rd_addr_i});
      check_field("ex_alu_control_o", held[6], {28'b0, ex_alu_control_i});
      check_field("ex_mem_op_o", held[7], {28'b0, ex_mem_op_i});
      check_field("ex_cf_op_o", held[8], {29'b0, ex_cf_op_i});
      check_field("ex_csr_op_o", held[9], {30'b0, ex_csr_op_i});
      check_field("ex_trap_valid_o", held[11], {31'b0, ex_trap_valid_i});
      if (held[0][0]) begin  // Data fields only for issued instructions.
        check_field("ex_pc_o", held_pc, ex_pc_i);
        check_field("ex_rs1_rdata_o", held[2], ex_rs1_rdata_i);
        check_field("ex_rs2_rdata_o", held[3], ex_rs2_rdata_i);
        check_field("ex_imm_o", held[4], ex_imm_i);
        check_field("ex_csr_rdata_o", held[10], ex_csr_rdata_i);
        check_field("ex_trap_mcause_o", held[12], {1'b0, ex_trap_mcause_i});
      end
    end
  end

endmodule

/* tests/tb_decode_top.sv */
`timescale 1ns/1ps

module tb_decode_top;

  localparam int MAX_LINES = 256;
  localparam int NCOLS     = 22;

  logic        clk;
  logic        reset;
  logic        insn_valid;
  logic [31:0] insn;
  logic [31:0] pc;
  logic        wb_valid;
  logic [4:0]  wb_rd_addr;
  logic [31:0] wb_rd_wdata;
  logic        wb_csr_we;
  logic [11:0] wb_csr_addr;
  logic [31:0] wb_csr_wdata;

  logic        ex_valid;
  logic [31:0] ex_pc;
  logic [31:0] ex_rs1_rdata;
  logic [31:0] ex_rs2_rdata;
  logic [31:0] ex_imm;
  logic [4:0]  ex_rd_addr;
  logic [3:0]  ex_alu_control;
  logic [3:0]  ex_mem_op;
  logic [2:0]  ex_cf_op;
  logic [1:0]  ex_csr_op;
  logic [31:0] ex_csr_rdata;
  logic        ex_trap_valid;
  logic [30:0] ex_trap_mcause;

  // Expected values of the line now on the inputs.
  logic        exp_active;
  int          exp_line;
  logic [31:0] exp_pc;
  logic [31:0] exp_cols [13];

  logic [31:0] stim [MAX_LINES][NCOLS];
  int          num_lines;
  int          cycle_count;
  int          cycle_limit;

  initial clk = 1'b0;
  always #20 clk = ~clk;

  decode_top decode_top_i (
    .clk_i            (clk),
    .reset_i          (reset),
    .insn_valid_i     (insn_valid),
    .insn_i           (insn),
    .pc_i             (pc),
    .wb_valid_i       (wb_valid),
    .wb_rd_addr_i     (wb_rd_addr),
    .wb_rd_wdata_i    (wb_rd_wdata),
    .wb_csr_we_i      (wb_csr_we),
    .wb_csr_addr_i    (wb_csr_addr),
    .wb_csr_wdata_i   (wb_csr_wdata),
    .ex_valid_o       (ex_valid),
    .ex_pc_o          (ex_pc),
    .ex_rs1_rdata_o   (ex_rs1_rdata),
    .ex_rs2_rdata_o   (ex_rs2_rdata),
    .ex_imm_o         (ex_imm),
    .ex_rd_addr_o     (ex_rd_addr),
    .ex_alu_control_o (ex_alu_control),
    .ex_mem_op_o      (ex_mem_op),
    .ex_cf_op_o       (ex_cf_op),
    .ex_csr_op_o      (ex_csr_op),
    .ex_csr_rdata_o   (ex_csr_rdata),
    .ex_trap_valid_o  (ex_trap_valid),
    .ex_trap_mcause_o (ex_trap_mcause)
  );

  decode_checker decode_checker_i (
    .clk_i            (clk),
    .exp_active_i     (exp_active),
    .exp_line_i       (exp_line),
    .exp_pc_i         (exp_pc),
    .exp_cols_i       (exp_cols),
    .ex_valid_i       (ex_valid),
    .ex_pc_i          (ex_pc),
    .ex_rs1_rdata_i   (ex_rs1_rdata),
    .ex_rs2_rdata_i   (ex_rs2_rdata),
    .ex_imm_i         (ex_imm),
    .ex_rd_addr_i     (ex_rd_addr),
    .ex_alu_control_i (ex_alu_control),
    .ex_mem_op_i      (ex_mem_op),
    .ex_cf_op_i       (ex_cf_op),
    .ex_csr_op_i      (ex_csr_op),
    .ex_csr_rdata_i   (ex_csr_rdata),
    .ex_trap_valid_i  (ex_trap_valid),
    .ex_trap_mcause_i (ex_trap_mcause)
  );

  // Lines starting with # are comments; every data line holds 22 hex columns.
  task automatic load_stim();
    int          fd;
    int          got;
    string       text;
    logic [31:0] f [NCOLS];
    fd = $fopen("tests/decode_stim.txt", "r");
    num_lines = 0;
    if (fd == 0) begin
      $display("Could not open the stimulus file tests/decode_stim.txt");
    end else begin
      while (!$feof(fd) && num_lines < MAX_LINES) begin
        got = $fgets(text, fd);
        if (got > 0 && text.len() > 0 && text[0] != "#") begin
          got = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                        f[20], f[21]);
          if (got == NCOLS) begin
            for (int c = 0; c < NCOLS; c++)
              stim[num_lines][c] = f[c];
            num_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_line(input int k);
    insn_valid   = stim[k][0][0];
    insn         = stim[k][1];
    pc           = stim[k][2];
    wb_valid     = stim[k][3][0];
    wb_rd_addr   = stim[k][4][4:0];
    wb_csr_we    = stim[k][6][0];
    wb_csr_addr  = stim[k][7][11:0];
    // Write data is filler unless its strobe is set.
    wb_rd_wdata  = wb_valid ? stim[k][5] : $urandom;
    wb_csr_wdata = wb_csr_we ? stim[k][8] : $urandom;
    for (int c = 0; c < 13; c++)
      exp_cols[c] = stim[k][9+c];
    exp_pc     = stim[k][2];  // The PC passes straight through the output register.
    exp_line   = k;
    exp_active = 1'b1;
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hac552338));
    reset        = 1'b1;
    insn_valid   = 1'b0;
    insn         = '0;
    pc           = '0;
    wb_valid     = 1'b0;
    wb_rd_addr   = '0;
    wb_rd_wdata  = '0;
    wb_csr_we    = 1'b0;
    wb_csr_addr  = '0;
    wb_csr_wdata = '0;
    exp_active   = 1'b0;
    exp_line     = 0;
    exp_pc       = '0;
    cycle_count  = 0;
    cycle_limit  = 0;
    for (int c = 0; c < 13; c++)
      exp_cols[c] = '0;
    load_stim();
    cycle_limit = 4 * num_lines + 20;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int k = 0; k < num_lines; k++) begin
      drive_line(k);
      @(negedge clk);
    end
    exp_active = 1'b0;
    insn_valid = 1'b0;
    wb_valid   = 1'b0;
    wb_csr_we  = 1'b0;
    @(negedge clk);
    $display("Lines: %0d, checks: %0d, errors: %0d", num_lines,
             decode_checker_i.check_count, decode_checker_i.error_count);
    if (decode_checker_i.error_count == 0 && num_lines > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* tests/decode_stim.txt */
# vld insn pc wbv wbrd wbdata csrwe csraddr csrdata, then expected:
# chk exv rs1 rs2 imm rd alu mem cf csrop csrdata trap cause (all hex)
0 00000000 000 0 00 00000000 0 000 00000000 0 0 00000000 00000000 00000000 00 0 0 0 0 00000000 0 00
0 00000000 000 1 01 11111111 0 000 00000000 0 0 00000000 00000000 00000000 00 0 0 0 0 00000000 0 00
0 00000000 000 1 02 22222222 0 000 00000000 0 0 00000000 00000000 00000000 00 0 0 0 0 00000000 0 00
1 002081B3 100 0 00 00000000 0 000 00000000 1 1 11111111 22222222 00000002 03 0 0 0 0 00000000 0 00
1 402082B3 104 1 01 AAAA0001 0 000 00000000 1 1 AAAA0001 22222222 00000402 05 1 0 0 0 00000000 0 00
1 00100333 108 0 00 00000000 0 000 00000000 1 1 00000000 AAAA0001 00000001 06 0 0 0 0 00000000 0 00
1 401153B3 10C 0 00 00000000 0 000 00000000 1 1 22222222 AAAA0001 00000401 07 7 0 0 0 00000000 0 00
1 001153B3 110 0 00 00000000 0 000 00000000 1 1 22222222 AAAA0001 00000001 07 6 0 0 0 00000000 0 00
1 FFC08413 114 0 00 00000000 0 000 00000000 1 1 AAAA0001 00000000 FFFFFFFC 08 0 0 0 0 00000000 0 00
1 FE20AC23 118 0 00 00000000 0 000 00000000 1 1 AAAA0001 22222222 FFFFFFF8 00 0 8 0 0 00000000 0 00
1 0020C863 11C 0 00 00000000 0 000 00000000 1 1 AAAA0001 22222222 00000010 00 3 0 3 0 00000000 0 00
1 123454B7 120 0 00 00000000 0 000 00000000 1 1 00000000 00000000 12345000 09 A 0 0 0 00000000 0 00
1 001000EF 124 0 00 00000000 0 000 00000000 1 1 00000124 00000000 00000800 01 0 0 1 0 00000000 0 00
0 00000000 000 0 00 00000000 1 340 CAFEF00D 0 0 00000000 00000000 00000000 00 0 0 0 0 00000000 0 00
1 34002573 128 0 00 00000000 1 340 12345678 1 1 00000000 00000000 00000340 0A 0 0 0 2 CAFEF00D 0 00
1 340095F3 12C 0 00 00000000 0 000 00000000 1 1 AAAA0001 00000000 00000340 0B 0 0 0 1 12345678 0 00
1 B0006673 130 0 00 00000000 0 000 00000000 1 1 00000000 00000000 FFFFFB00 0C 0 0 0 2 00000010 0 00
1 00000073 134 0 00 00000000 0 000 00000000 1 1 00000134 00000073 00000000 00 0 0 0 0 00000000 1 0B
1 00100073 138 0 00 00000000 0 000 00000000 1 1 00000138 00100073 00000001 00 0 0 0 0 00000000 1 03
1 FFFFFFFF 13C 0 00 00000000 0 000 00000000 1 1 0000013C FFFFFFFF FFFFFFFF 00 0 0 0 0 00000000 1 02
0 002081B3 140 0 00 00000000 0 000 00000000 0 0 00000000 00000000 00000000 00 0 0 0 0 00000000 0 00
1 00412683 144 0 00 00000000 0 000 00000000 1 1 22222222 00000000 00000004 0D 0 3 0 0 00000000 0 00
0 00000000 000 0 00 00000000 0 000 00000000 0 0 00000000 00000000 00000000 00 0 0 0 0 00000000 0 00

/* src.f */
source/rv_pkg.sv
source/decoder.sv
source/extend.sv
source/regfile.sv
source/csrfile.sv
source/id_stage.sv
source/issue_ctrl.sv
source/decode_top.sv
tests/decode_checker.sv
tests/tb_decode_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decode_top
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(BUILD_DIR)
